// File: common/mem_map_pkg.sv
// ----------------------------------------
// Core-side address map and access sizes.
// Only the low 24 address bits reach a chip,
// so regions above that alias on the bus.
// ----------------------------------------

package mem_map_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Access size, straight from funct3
    // Stores use the signed codes; unknown codes act as a word
    typedef enum logic [2:0] {
        size_b  = 3'b000,
        size_h  = 3'b001,
        size_w  = 3'b010,
        size_bu = 3'b100,
        size_hu = 3'b101
    } size_e;

    // 8 KB of flash at the bottom of the map
    localparam addr_t flash_size_default = 32'h0000_2000;

    // Single GPIO output register
    localparam addr_t gpio_base_default = 32'h4000_1000;

    // Address bits sent after the command byte
    localparam int dev_addr_bits = 24;

endpackage

// File: common/spi_pkg.sv
// ----------------------------------------
// Request and response types of the SPI
// master. Both chips take the same 03h/02h
// command set with a 24-bit address.
// ----------------------------------------

package spi_pkg;

    localparam logic [7:0] cmd_read  = 8'h03;
    localparam logic [7:0] cmd_write = 8'h02;

    // Which chip select a transaction drives
    typedef enum logic {
        dev_flash = 1'b0,
        dev_ram   = 1'b1
    } dev_e;

    // One complete SPI transaction, 71 bits
    typedef struct packed {
        logic [7:0]                            cmd;
        logic [mem_map_pkg::dev_addr_bits-1:0] addr;
        // First byte on the wire sits in bits 31:24
        logic [31:0]                           wdata;
        // 8, 16 or 32
        logic [5:0]                            nbits;
        dev_e                                  dev;
    } spi_req_t;

    // Last bit received lands in bit 0
    typedef struct packed {
        logic [31:0] rdata;
    } spi_rsp_t;

endpackage

// File: spi/spi_master.sv
// ----------------------------------------
// SPI mode 0, sclk at half the clock rate.
// Sends 8 cmd + 24 addr + nbits data bits,
// MSB first. Start to done takes
// 2*(32+nbits)+2 cycles; start is ignored
// while busy.
// ----------------------------------------
`timescale 1ns/1ps

module spi_master (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  spi_pkg::spi_req_t req,
    input  logic              spi_miso,
    output logic              busy,
    output logic              done,
    output spi_pkg::spi_rsp_t rsp,
    output logic              spi_sclk,
    output logic              spi_mosi,
    output logic              cs_n
);

    logic [63:0] shreg;
    logic [31:0] rx;
    // Remaining sclk half periods
    logic [7:0]  hcnt;
    logic        load;
    logic        shifting;
    logic        sclk_rise;
    logic        sclk_fall;

    assign load      = start && !busy;
    assign shifting  = busy && (hcnt != 8'd0);
    assign sclk_rise = shifting && !spi_sclk;
    assign sclk_fall = shifting && spi_sclk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            cs_n     <= 1'b1;
            spi_sclk <= 1'b0;
            hcnt     <= 8'd0;
        end else if (load) begin
            busy <= 1'b1;
            cs_n <= 1'b0;
            hcnt <= ({2'b00, req.nbits} + 8'd32) << 1;
        end else if (shifting) begin
            spi_sclk <= !spi_sclk;
            hcnt     <= hcnt - 8'd1;
        end else if (done) begin
            // Chip select rises after the done cycle
            done <= 1'b0;
            busy <= 1'b0;
            cs_n <= 1'b1;
        end else if (busy) begin
            // One idle sclk-low cycle before done
            done <= 1'b1;
        end
    end

    // MOSI moves on the falling edge, MISO is taken on the rising one
    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= {req.cmd, req.addr, req.wdata};
        end else if (sclk_fall) begin
            shreg <= {shreg[62:0], 1'b0};
        end
        if (sclk_rise) begin
            rx <= {rx[30:0], spi_miso};
        end
    end

    // Idle low between transactions
    assign spi_mosi = shreg[63] && !cs_n;
    assign rsp      = '{rdata: rx};

endmodule

// File: spi/spi_arbiter.sv
// ----------------------------------------
// Fixed priority, data over fetch. A peer
// holds its request until its done pulse.
// Start comes 1 cycle after a valid request.
// ----------------------------------------
`timescale 1ns/1ps

module spi_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  spi_pkg::spi_req_t fetch_req,
    input  logic              data_valid,
    input  spi_pkg::spi_req_t data_req,
    input  logic              busy,
    input  logic              done,
    input  spi_pkg::spi_rsp_t rsp,
    input  logic              cs_n,
    output logic              start,
    output spi_pkg::spi_req_t req,
    output logic              fetch_done,
    output logic              data_done,
    output spi_pkg::spi_rsp_t fetch_rsp,
    output spi_pkg::spi_rsp_t data_rsp,
    output logic              flash_cs_n,
    output logic              ram_cs_n
);

    logic          owner_data;
    spi_pkg::dev_e cur_dev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start      <= 1'b0;
            owner_data <= 1'b0;
            cur_dev    <= spi_pkg::dev_flash;
        end else begin
            start <= 1'b0;
            // Master reports busy only from the cycle after start
            if (!busy && !start) begin
                if (data_valid) begin
                    start      <= 1'b1;
                    owner_data <= 1'b1;
                    cur_dev    <= data_req.dev;
                end else if (fetch_valid) begin
                    start      <= 1'b1;
                    owner_data <= 1'b0;
                    cur_dev    <= fetch_req.dev;
                end
            end
        end
    end

    // The owner holds its request until its done pulse
    assign req = owner_data ? data_req : fetch_req;

    assign fetch_done = done && !owner_data;
    assign data_done  = done && owner_data;
    assign fetch_rsp  = rsp;
    assign data_rsp   = rsp;

    assign flash_cs_n = (cur_dev == spi_pkg::dev_flash) ? cs_n : 1'b1;
    assign ram_cs_n   = (cur_dev == spi_pkg::dev_ram) ? cs_n : 1'b1;

endmodule

// File: src/fetch_unit.sv
// ----------------------------------------
// Instruction fetch. Holds one word; any
// move of instr_addr costs a full 32-bit
// flash read, no prefetch of the next word.
// ----------------------------------------
`timescale 1ns/1ps

module fetch_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_map_pkg::addr_t instr_addr,
    input  logic               fetch_done,
    input  spi_pkg::spi_rsp_t  fetch_rsp,
    output mem_map_pkg::word_t instr_data,
    output logic               instr_ready,
    output logic               fetch_valid,
    output spi_pkg::spi_req_t  fetch_req
);

    mem_map_pkg::addr_t held_addr;
    logic               held_ok;
    logic               hit;
    logic               need_fetch;

    assign hit         = held_ok && (instr_addr == held_addr);
    assign need_fetch  = !fetch_valid && !hit;
    assign instr_ready = hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_ok     <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (fetch_done) begin
            held_ok     <= 1'b1;
            fetch_valid <= 1'b0;
        end else if (need_fetch) begin
            held_ok     <= 1'b0;
            fetch_valid <= 1'b1;
        end
    end

    // Flash bytes arrive lowest address first
    always_ff @(posedge clk) begin
        if (need_fetch) begin
            held_addr <= instr_addr;
        end
        if (fetch_done) begin
            instr_data <= {fetch_rsp.rdata[7:0], fetch_rsp.rdata[15:8],
                           fetch_rsp.rdata[23:16], fetch_rsp.rdata[31:24]};
        end
    end

    assign fetch_req = '{cmd:   spi_pkg::cmd_read,
                         addr:  held_addr[mem_map_pkg::dev_addr_bits-1:0],
                         wdata: 32'h0,
                         nbits: 6'd32,
                         dev:   spi_pkg::dev_flash};

endmodule

// File: src/data_unit.sv
// ----------------------------------------
// Data side: GPIO register, flash reads and
// RAM loads/stores. Loads are zero-extended.
// Address, data and size must stay stable
// until mem_ready. gpio_width up to 32.
// ----------------------------------------
`timescale 1ns/1ps

module data_unit #(
    parameter mem_map_pkg::addr_t flash_size = mem_map_pkg::flash_size_default,
    parameter mem_map_pkg::addr_t gpio_base  = mem_map_pkg::gpio_base_default,
    parameter int                 gpio_width = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_map_pkg::addr_t    mem_addr,
    input  mem_map_pkg::word_t    mem_wdata,
    input  mem_map_pkg::size_e    mem_size,
    input  logic                  mem_we,
    input  logic                  mem_re,
    input  logic                  data_done,
    input  spi_pkg::spi_rsp_t     data_rsp,
    output mem_map_pkg::word_t    mem_rdata,
    output logic                  mem_ready,
    output logic [gpio_width-1:0] gpio_out,
    output logic                  data_valid,
    output spi_pkg::spi_req_t     data_req
);

    logic strobe;
    logic is_gpio;
    logic is_flash;
    logic spi_access;

    // Bits on the wire for each size
    function automatic logic [5:0] size_bits(mem_map_pkg::size_e size);
        case (size)
            mem_map_pkg::size_b, mem_map_pkg::size_bu: return 6'd8;
            mem_map_pkg::size_h, mem_map_pkg::size_hu: return 6'd16;
            default: return 6'd32;
        endcase
    endfunction

    // Received bytes are in address order, first one highest
    function automatic mem_map_pkg::word_t unpack(mem_map_pkg::size_e size,
                                                  logic [31:0] r);
        case (size)
            mem_map_pkg::size_b, mem_map_pkg::size_bu: return {24'h0, r[7:0]};
            mem_map_pkg::size_h, mem_map_pkg::size_hu: return {16'h0, r[7:0], r[15:8]};
            default: return {r[7:0], r[15:8], r[23:16], r[31:24]};
        endcase
    endfunction

    assign strobe     = mem_we || mem_re;
    assign is_gpio    = (mem_addr == gpio_base);
    assign is_flash   = (mem_addr < flash_size);
    assign spi_access = strobe && !is_gpio;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ready  <= 1'b0;
            data_valid <= 1'b0;
            gpio_out   <= '0;
        end else begin
            mem_ready <= 1'b0;
            // GPIO answers straight away
            if (strobe && is_gpio) begin
                mem_ready <= 1'b1;
                if (mem_we) begin
                    gpio_out <= mem_wdata[gpio_width-1:0];
                end
            end else if (spi_access) begin
                data_valid <= 1'b1;
            end
            if (data_done) begin
                data_valid <= 1'b0;
                mem_ready  <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (spi_access) begin
            data_req.cmd   <= mem_we ? spi_pkg::cmd_write : spi_pkg::cmd_read;
            data_req.addr  <= mem_addr[mem_map_pkg::dev_addr_bits-1:0];
            // Low byte first; nbits cuts off what a short store doesn't need
            data_req.wdata <= {mem_wdata[7:0], mem_wdata[15:8],
                               mem_wdata[23:16], mem_wdata[31:24]};
            data_req.nbits <= size_bits(mem_size);
            data_req.dev   <= is_flash ? spi_pkg::dev_flash : spi_pkg::dev_ram;
        end
        if (strobe && is_gpio && mem_re) begin
            mem_rdata <= mem_map_pkg::word_t'(gpio_out);
        end else if (data_done && data_req.cmd == spi_pkg::cmd_read) begin
            mem_rdata <= unpack(mem_size, data_rsp.rdata);
        end
    end

endmodule

// File: src/mem_ctl.sv
// ----------------------------------------
// Memory controller top. Fetch and data
// share one SPI bus; data wins a tie and a
// started transaction always completes.
// ----------------------------------------
`timescale 1ns/1ps

module mem_ctl #(
    parameter mem_map_pkg::addr_t flash_size = mem_map_pkg::flash_size_default,
    parameter mem_map_pkg::addr_t gpio_base  = mem_map_pkg::gpio_base_default,
    parameter int                 gpio_width = 5
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_map_pkg::addr_t    instr_addr,
    output mem_map_pkg::word_t    instr_data,
    output logic                  instr_ready,
    input  mem_map_pkg::addr_t    mem_addr,
    input  mem_map_pkg::word_t    mem_wdata,
    input  mem_map_pkg::size_e    mem_size,
    input  logic                  mem_we,
    input  logic                  mem_re,
    output mem_map_pkg::word_t    mem_rdata,
    output logic                  mem_ready,
    output logic [gpio_width-1:0] gpio_out,
    output logic                  spi_sclk,
    output logic                  spi_mosi,
    output logic                  flash_cs_n,
    output logic                  ram_cs_n,
    input  logic                  spi_miso
);

    logic              fetch_valid;
    logic              fetch_done;
    spi_pkg::spi_req_t fetch_req;
    spi_pkg::spi_rsp_t fetch_rsp;
    logic              data_valid;
    logic              data_done;
    spi_pkg::spi_req_t data_req;
    spi_pkg::spi_rsp_t data_rsp;

    // Arbiter to master
    logic              start;
    logic              busy;
    logic              done;
    logic              cs_n;
    spi_pkg::spi_req_t req;
    spi_pkg::spi_rsp_t rsp;

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .fetch_done  (fetch_done),
        .fetch_rsp   (fetch_rsp),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req)
    );

    data_unit #(
        .flash_size (flash_size),
        .gpio_base  (gpio_base),
        .gpio_width (gpio_width)
    ) u_data (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_size   (mem_size),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .data_done  (data_done),
        .data_rsp   (data_rsp),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .gpio_out   (gpio_out),
        .data_valid (data_valid),
        .data_req   (data_req)
    );

    spi_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .data_valid  (data_valid),
        .data_req    (data_req),
        .busy        (busy),
        .done        (done),
        .rsp         (rsp),
        .cs_n        (cs_n),
        .start       (start),
        .req         (req),
        .fetch_done  (fetch_done),
        .data_done   (data_done),
        .fetch_rsp   (fetch_rsp),
        .data_rsp    (data_rsp),
        .flash_cs_n  (flash_cs_n),
        .ram_cs_n    (ram_cs_n)
    );

    spi_master u_spi (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .req      (req),
        .spi_miso (spi_miso),
        .busy     (busy),
        .done     (done),
        .rsp      (rsp),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .cs_n     (cs_n)
    );

endmodule

// File: verif/spi_mem_model.sv
// ----------------------------------------
// Serial flash and RAM chips on one bus.
// 03h read, 02h write, 24-bit address.
// Flash ignores writes and is filled by the
// testbench; RAM starts with a fixed pattern.
// ----------------------------------------
`timescale 1ns/1ps

module spi_mem_model #(
    parameter int flash_abits = 13,
    parameter int ram_abits   = 16
) (
    input  logic spi_sclk,
    input  logic spi_mosi,
    input  logic flash_cs_n,
    input  logic ram_cs_n,
    output logic spi_miso
);

    logic [7:0]  flash_mem [2**flash_abits];
    logic [7:0]  ram_mem [2**ram_abits];
    // Command byte and address as shifted in
    logic [31:0] hdr;
    logic [7:0]  cnt;
    logic [7:0]  wbyte;
    logic [23:0] byte_addr;
    logic [7:0]  rd_byte;
    logic        idle;

    assign idle      = flash_cs_n && ram_cs_n;
    // Byte that holds data bit cnt-32
    assign byte_addr = hdr[23:0] + 24'((cnt - 8'd32) >> 3);
    assign rd_byte   = !flash_cs_n ? flash_mem[byte_addr[flash_abits-1:0]]
                                   : ram_mem[byte_addr[ram_abits-1:0]];

    initial begin
        for (int i = 0; i < 2**ram_abits; i++) begin
            ram_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
    end

    // Chip takes MOSI on the rising edge
    always @(posedge spi_sclk or posedge idle) begin
        if (idle) begin
            cnt <= 8'd0;
        end else begin
            cnt <= cnt + 8'd1;
            if (cnt < 8'd32) begin
                hdr <= {hdr[30:0], spi_mosi};
            end else begin
                wbyte <= {wbyte[6:0], spi_mosi};
                if (cnt[2:0] == 3'd7 && !ram_cs_n && hdr[31:24] == spi_pkg::cmd_write) begin
                    ram_mem[byte_addr[ram_abits-1:0]] = {wbyte[6:0], spi_mosi};
                end
            end
        end
    end

    // Read data moves on the falling edge, MSB of each byte first
    always @(negedge spi_sclk or posedge idle) begin
        if (idle) begin
            spi_miso <= 1'b0;
        end else if (cnt >= 8'd32) begin
            spi_miso <= rd_byte[~cnt[2:0]];
        end
    end

endmodule

// File: verif/mem_ctl_props.sv
// ----------------------------------------
// Bus checks bound into spi_arbiter.
// All are off while rst_n is low.
// ----------------------------------------
`timescale 1ns/1ps

module mem_ctl_props (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic fetch_valid,
    input logic data_valid,
    input logic fetch_done,
    input logic data_done,
    input logic flash_cs_n,
    input logic ram_cs_n
);

    // One chip on the bus at a time, with a high cycle before the other one
    cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        (flash_cs_n || (ram_cs_n && $past(ram_cs_n))) &&
        (ram_cs_n || (flash_cs_n && $past(flash_cs_n))))
        else $error("flash_cs_n and ram_cs_n overlap or switch without a gap");

    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !(start && busy))
        else $error("start issued while the SPI master is busy");

    // A done pulse reaches only the one peer still waiting on it
    done_one_peer: assert property (@(posedge clk) disable iff (!rst_n)
        (!fetch_done || (fetch_valid && !data_done)) && (!data_done || data_valid))
        else $error("done pulse sent to both peers or to a peer that is not waiting");

endmodule

bind spi_arbiter mem_ctl_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .fetch_valid (fetch_valid),
    .data_valid  (data_valid),
    .fetch_done  (fetch_done),
    .data_done   (data_done),
    .flash_cs_n  (flash_cs_n),
    .ram_cs_n    (ram_cs_n)
);

// File: verif/tb_mem_ctl.sv
// ----------------------------------------
// Testbench for mem_ctl with default parameters.
// A chip model sits on the SPI pins. Flash is
// preloaded from an xorshift stream and the
// TB keeps its own copy of both arrays.
// ----------------------------------------
`timescale 1ns/1ps

module tb_mem_ctl;

    localparam int flash_abits = 13;
    localparam int ram_abits   = 16;
    localparam int gpio_bits   = 5;
    localparam int timeout_cyc = 600;

    logic                  clk;
    logic                  rst_n;
    mem_map_pkg::addr_t    instr_addr;
    mem_map_pkg::word_t    instr_data;
    logic                  instr_ready;
    mem_map_pkg::addr_t    mem_addr;
    mem_map_pkg::word_t    mem_wdata;
    mem_map_pkg::size_e    mem_size;
    logic                  mem_we;
    logic                  mem_re;
    mem_map_pkg::word_t    mem_rdata;
    logic                  mem_ready;
    logic [gpio_bits-1:0]  gpio_out;
    logic                  spi_sclk;
    logic                  spi_mosi;
    logic                  flash_cs_n;
    logic                  ram_cs_n;
    logic                  spi_miso;

    // Reference copies of the chip arrays
    logic [7:0]  ref_flash [2**flash_abits];
    logic [7:0]  ref_ram [2**ram_abits];
    logic [31:0] rng;
    int          n_tests;
    int          n_checks;
    int          n_errors;
    bit          aborted;

    mem_ctl u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_addr  (instr_addr),
        .instr_data  (instr_data),
        .instr_ready (instr_ready),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_size    (mem_size),
        .mem_we      (mem_we),
        .mem_re      (mem_re),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .gpio_out    (gpio_out),
        .spi_sclk    (spi_sclk),
        .spi_mosi    (spi_mosi),
        .flash_cs_n  (flash_cs_n),
        .ram_cs_n    (ram_cs_n),
        .spi_miso    (spi_miso)
    );

    spi_mem_model #(
        .flash_abits (flash_abits),
        .ram_abits   (ram_abits)
    ) u_mem (
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .flash_cs_n (flash_cs_n),
        .ram_cs_n   (ram_cs_n),
        .spi_miso   (spi_miso)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic int byte_count(input mem_map_pkg::size_e size);
        case (size)
            mem_map_pkg::size_b, mem_map_pkg::size_bu: return 1;
            mem_map_pkg::size_h, mem_map_pkg::size_hu: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic mem_map_pkg::size_e pick_size(input logic [31:0] r, input bit store);
        case (store ? r % 32'd3 : r % 32'd5)
            32'd0: return mem_map_pkg::size_b;
            32'd1: return mem_map_pkg::size_h;
            32'd2: return mem_map_pkg::size_w;
            32'd3: return mem_map_pkg::size_bu;
            default: return mem_map_pkg::size_hu;
        endcase
    endfunction

    // Zero-extended little-endian value of a load
    function automatic mem_map_pkg::word_t expect_load(input bit is_ram,
                                                       input mem_map_pkg::addr_t a,
                                                       input mem_map_pkg::size_e size);
        mem_map_pkg::addr_t ai;
        mem_map_pkg::word_t v;
        v = '0;
        for (int i = 0; i < byte_count(size); i++) begin
            ai = a + 32'(i);
            v[8*i +: 8] = is_ram ? ref_ram[ai[ram_abits-1:0]] : ref_flash[ai[flash_abits-1:0]];
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        n_tests++;
        $display("test %-10s done, %0d error(s)", name, n_errors - errs_before);
    endtask

    // Outputs are sampled on the falling edge; lat counts cycles waited
    task automatic wait_mem_ready(input string name, output int lat);
        bit seen;
        lat = 0;
        seen = 1'b0;
        while (!seen && !aborted) begin
            @(negedge clk);
            lat++;
            seen = mem_ready;
            if (!seen && lat >= timeout_cyc) begin
                $display("%s: timed out waiting for mem_ready", name);
                n_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic wait_instr_ready(input string name);
        bit seen;
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && !aborted) begin
            @(negedge clk);
            n++;
            seen = instr_ready;
            if (!seen && n >= timeout_cyc) begin
                $display("%s: timed out waiting for instr_ready", name);
                n_errors++;
                aborted = 1'b1;
            end
        end
    endtask

    // One-cycle strobe, then hold until mem_ready
    task automatic data_access(input bit we, input mem_map_pkg::addr_t a,
                               input mem_map_pkg::word_t wd, input mem_map_pkg::size_e size,
                               input string name, output int lat);
        @(posedge clk);
        mem_addr  <= a;
        mem_wdata <= wd;
        mem_size  <= size;
        mem_we    <= we;
        mem_re    <= !we;
        @(posedge clk);
        mem_we <= 1'b0;
        mem_re <= 1'b0;
        wait_mem_ready(name, lat);
    endtask

    task automatic reset_state();
        int e0;
        e0 = n_errors;
        @(negedge clk);
        check("reset instr_ready", 32'd0, 32'(instr_ready));
        check("reset mem_ready", 32'd0, 32'(mem_ready));
        check("reset flash_cs_n", 32'd1, 32'(flash_cs_n));
        check("reset ram_cs_n", 32'd1, 32'(ram_cs_n));
        check("reset spi_sclk", 32'd0, 32'(spi_sclk));
        check("reset gpio_out", 32'd0, 32'(gpio_out));
        report_test("reset", e0);
    endtask

    task automatic random_fetches();
        mem_map_pkg::addr_t a;
        int e0;
        e0 = n_errors;
        for (int i = 0; i < 12 && !aborted; i++) begin
            a = next_rand() & (mem_map_pkg::flash_size_default - 32'd4);
            @(posedge clk);
            instr_addr <= a;
            wait_instr_ready("fetch");
            check("fetch", expect_load(1'b0, a, mem_map_pkg::size_w), instr_data);
        end
        report_test("fetch", e0);
    endtask

    task automatic ram_store_load();
        mem_map_pkg::addr_t a;
        mem_map_pkg::addr_t ai;
        mem_map_pkg::word_t wd;
        mem_map_pkg::size_e ssize;
        mem_map_pkg::size_e lsize;
        int lat;
        int e0;
        e0 = n_errors;
        for (int i = 0; i < 16 && !aborted; i++) begin
            a = mem_map_pkg::flash_size_default + (next_rand() & 32'h0000_0ffc);
            ssize = pick_size(next_rand(), 1'b1);
            lsize = pick_size(next_rand(), 1'b0);
            wd = next_rand();
            data_access(1'b1, a, wd, ssize, "ram store", lat);
            for (int j = 0; j < byte_count(ssize); j++) begin
                ai = a + 32'(j);
                ref_ram[ai[ram_abits-1:0]] = wd[8*j +: 8];
            end
            data_access(1'b0, a, next_rand(), lsize, "ram load", lat);
            check("ram load", expect_load(1'b1, a, lsize), mem_rdata);
        end
        report_test("ram", e0);
    endtask

    task automatic flash_loads();
        mem_map_pkg::addr_t a;
        mem_map_pkg::size_e lsize;
        int lat;
        int e0;
        e0 = n_errors;
        for (int i = 0; i < 8 && !aborted; i++) begin
            a = next_rand() & (mem_map_pkg::flash_size_default - 32'd4);
            lsize = pick_size(next_rand(), 1'b0);
            data_access(1'b0, a, 32'h0, lsize, "flash load", lat);
            check("flash load", expect_load(1'b0, a, lsize), mem_rdata);
        end
        report_test("flash", e0);
    endtask

    task automatic gpio_write_read();
        mem_map_pkg::word_t wd;
        int lat;
        int e0;
        e0 = n_errors;
        for (int i = 0; i < 4 && !aborted; i++) begin
            wd = next_rand();
            data_access(1'b1, mem_map_pkg::gpio_base_default, wd, mem_map_pkg::size_w,
                        "gpio write", lat);
            check("gpio write latency", 32'd1, 32'(lat));
            check("gpio_out", 32'(wd[gpio_bits-1:0]), 32'(gpio_out));
            data_access(1'b0, mem_map_pkg::gpio_base_default, next_rand(),
                        mem_map_pkg::size_w, "gpio read", lat);
            check("gpio read latency", 32'd1, 32'(lat));
            check("gpio read", 32'(wd[gpio_bits-1:0]), mem_rdata);
        end
        report_test("gpio", e0);
    endtask

    // Data and fetch ask in the same cycle and data finishes first
    task automatic fetch_data_contention();
        mem_map_pkg::addr_t a_ins;
        mem_map_pkg::addr_t a_dat;
        bit got_mem;
        bit got_ins;
        int n;
        int e0;
        e0 = n_errors;
        a_ins = (instr_addr + 32'd4) & (mem_map_pkg::flash_size_default - 32'd4);
        a_dat = mem_map_pkg::flash_size_default + (next_rand() & 32'h0000_0ffc);
        @(posedge clk);
        instr_addr <= a_ins;
        mem_addr   <= a_dat;
        mem_size   <= mem_map_pkg::size_w;
        mem_re     <= 1'b1;
        @(posedge clk);
        mem_re <= 1'b0;
        got_mem = 1'b0;
        got_ins = 1'b0;
        n = 0;
        while (!(got_mem && got_ins) && !aborted) begin
            @(negedge clk);
            n++;
            if (instr_ready && !got_ins) begin
                got_ins = 1'b1;
                check("contention order", 32'd1, 32'(got_mem));
                check("contention fetch", expect_load(1'b0, a_ins, mem_map_pkg::size_w),
                      instr_data);
            end
            if (mem_ready && !got_mem) begin
                got_mem = 1'b1;
                check("contention load", expect_load(1'b1, a_dat, mem_map_pkg::size_w),
                      mem_rdata);
            end
            if (!(got_mem && got_ins) && n >= timeout_cyc) begin
                $display("contention: timed out waiting for mem_ready and instr_ready");
                n_errors++;
                aborted = 1'b1;
            end
        end
        report_test("contention", e0);
    endtask

    initial begin
        logic [31:0] r;
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_addr = '0;
        mem_addr   = '0;
        mem_wdata  = '0;
        mem_size   = mem_map_pkg::size_w;
        mem_we     = 1'b0;
        mem_re     = 1'b0;
        rng        = 32'h34df;
        n_tests    = 0;
        n_checks   = 0;
        n_errors   = 0;
        aborted    = 1'b0;
        for (int i = 0; i < 2**flash_abits; i++) begin
            r = next_rand();
            u_mem.flash_mem[i] = r[7:0];
            ref_flash[i] = r[7:0];
        end
        // Same fill rule as the RAM chip model
        for (int i = 0; i < 2**ram_abits; i++) begin
            ref_ram[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        if (!aborted) random_fetches();
        if (!aborted) ram_store_load();
        if (!aborted) flash_loads();
        if (!aborted) gpio_write_read();
        if (!aborted) fetch_data_contention();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: mem_ctl.f
common/mem_map_pkg.sv
common/spi_pkg.sv
spi/spi_master.sv
spi/spi_arbiter.sv
src/fetch_unit.sv
src/data_unit.sv
src/mem_ctl.sv
verif/spi_mem_model.sv
verif/mem_ctl_props.sv
verif/tb_mem_ctl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mem_ctl testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_mem_ctl -Mdir obj_dir -f mem_ctl.f > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_mem_ctl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
